// ==== hdl/ecc_pkg.sv ====
package ecc_pkg;

  localparam int AMBA_WORD       = 32;
  localparam int AMBA_ADDR_WIDTH = 20;
  localparam int SYN_BITS        = $clog2(AMBA_WORD); // Hamming index width

  typedef logic [AMBA_WORD-1:0]       word_t;
  typedef logic [AMBA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [1:0]                 op_t;
  typedef logic [1:0]                 width_t;
  typedef logic [1:0]                 err_cnt_t;

  // CTRL operation codes
  localparam op_t OP_ENC  = 2'd0;
  localparam op_t OP_DEC  = 2'd1;
  localparam op_t OP_CHAN = 2'd2;
  localparam op_t OP_RSVD = 2'd3;  // Stored but never started

  // CODEWORD_WIDTH codes, 3 acts as W32
  localparam width_t W8  = 2'd0;
  localparam width_t W16 = 2'd1;
  localparam width_t W32 = 2'd2;

  localparam addr_t REG_CTRL           = 20'h00;
  localparam addr_t REG_DATA_IN        = 20'h04;
  localparam addr_t REG_CODEWORD_WIDTH = 20'h08;
  localparam addr_t REG_NOISE          = 20'h0C;
  localparam addr_t REG_DATA_OUT       = 20'h10;
  localparam addr_t REG_NUM_OF_ERRORS  = 20'h14;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  // Bits of the codeword that exist at the given width
  function automatic word_t cw_mask(width_t w);
    case (w)
      W8:      return 32'h0000_00FF;
      W16:     return 32'h0000_FFFF;
      default: return 32'hFFFF_FFFF;
    endcase
  endfunction

endpackage

// ==== hdl/ecc_ctrl_if.sv ====
`timescale 1ns/10ps

interface ecc_ctrl_if
  import ecc_pkg::*;
();

  // Request side, from the register bank
  logic     start;
  op_t      op;
  width_t   width;
  word_t    data_in;
  word_t    noise;

  // Result side, held by the core between done pulses
  word_t    data_out;
  err_cnt_t num_err;
  logic     done;

  modport regs (
    output start, op, width, data_in, noise,
    input  data_out, num_err, done
  );

  modport core (
    input  start, op, width, data_in, noise,
    output data_out, num_err, done
  );

endinterface

// ==== hdl/apb_regs.sv ====
`timescale 1ns/10ps

module apb_regs
  import ecc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  addr_t      paddr,
  input  word_t      pwdata,
  output word_t      prdata,
  ecc_ctrl_if.regs   ctrl
);

  apb_state_e state;   // Phase seen in the previous cycle
  apb_state_e phase;   // Phase of the current cycle

  op_t    op_q;
  width_t width_q;
  word_t  data_in_q;
  word_t  noise_q;
  logic   start_q;

  logic   wr_en;
  logic   rd_en;

  // An access cycle is only valid right after a setup cycle
  always_comb begin : phase_dec
    if (!psel) begin
      phase = ST_IDLE;
    end else if (!penable) begin
      phase = ST_SETUP;
    end else if (state == ST_SETUP) begin
      phase = ST_ACCESS;
    end else begin
      phase = ST_IDLE;  // penable without a preceding setup
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= phase;
    end
  end

  assign wr_en = (phase == ST_ACCESS) && pwrite;
  assign rd_en = (phase == ST_ACCESS) && !pwrite;

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q      <= OP_ENC;
      width_q   <= W8;
      data_in_q <= '0;
      noise_q   <= '0;
      start_q   <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (wr_en) begin
        case (paddr)
          REG_CTRL: begin
            op_q    <= pwdata[1:0];
            start_q <= (pwdata[1:0] != OP_RSVD);
          end
          REG_DATA_IN:        data_in_q <= pwdata;
          REG_CODEWORD_WIDTH: width_q   <= pwdata[1:0];
          REG_NOISE:          noise_q   <= pwdata;
          default: ;  // Read-only and unmapped offsets
        endcase
      end
    end
  end

  assign ctrl.start   = start_q;
  assign ctrl.op      = op_q;
  assign ctrl.width   = width_q;
  assign ctrl.data_in = data_in_q;
  assign ctrl.noise   = noise_q;

  // Zero-wait read path
  always_comb begin : read_mux
    prdata = '0;
    if (rd_en) begin
      case (paddr)
        REG_CTRL:           prdata = word_t'(op_q);
        REG_DATA_IN:        prdata = data_in_q;
        REG_CODEWORD_WIDTH: prdata = word_t'(width_q);
        REG_NOISE:          prdata = noise_q;
        REG_DATA_OUT:       prdata = ctrl.data_out;
        REG_NUM_OF_ERRORS:  prdata = word_t'(ctrl.num_err);
        default:            prdata = '0;
      endcase
    end
  end

endmodule

// ==== hdl/ecc_enc.sv ====
`timescale 1ns/10ps

module ecc_enc
  import ecc_pkg::*;
(
  input  width_t width,
  input  word_t  data,
  output word_t  codeword
);

  word_t mask;
  word_t placed;     // Data bits at their Hamming positions
  word_t with_par;   // Plus the parity bits, overall parity still open

  assign mask = cw_mask(width);

  // Data bits go to the non-power-of-two positions in ascending order
  always_comb begin : place_data
    int unsigned k;
    placed = '0;
    k = 0;
    for (int i = 3; i < AMBA_WORD; i++) begin
      if ((i & (i - 1)) != 0) begin
        placed[i] = data[k] & mask[i];
        k++;
      end
    end
  end

  // Parity positions above n only see masked data, so they come out zero
  always_comb begin : parity_bits
    logic p;
    with_par = placed;
    for (int b = 0; b < SYN_BITS; b++) begin
      p = 1'b0;
      // Position 2^b is still zero in placed, so it can stay in the sum
      for (int i = 1; i < AMBA_WORD; i++) begin
        if (((i >> b) & 1) != 0) begin
          p = p ^ placed[i];
        end
      end
      with_par[1 << b] = p;
    end
  end

  // Bit 0 makes the whole codeword even
  assign codeword = {with_par[AMBA_WORD-1:1], ^with_par[AMBA_WORD-1:1]};

endmodule

// ==== hdl/ecc_dec.sv ====
`timescale 1ns/10ps

module ecc_dec
  import ecc_pkg::*;
(
  input  width_t   width,
  input  word_t    codeword,
  output word_t    data,
  output err_cnt_t num_err
);

  word_t               mask;
  word_t               cw_m;
  word_t               fixed;
  logic [SYN_BITS-1:0] syn;
  logic                par;

  assign mask = cw_mask(width);
  assign cw_m = codeword & mask;  // Bits above n take no part

  always_comb begin : syndrome
    syn = '0;
    for (int i = 1; i < AMBA_WORD; i++) begin
      if (cw_m[i]) begin
        syn = syn ^ SYN_BITS'(i);
      end
    end
  end

  assign par = ^cw_m;

  // Odd parity means one flipped bit, even parity with a syndrome means two
  always_comb begin : correct
    fixed   = cw_m;
    num_err = 2'd0;
    if (par) begin
      fixed[syn] = ~cw_m[syn];  // Syndrome 0 points at bit 0
      num_err    = 2'd1;
    end else if (syn != '0) begin
      num_err = 2'd2;
    end
  end

  // Syndrome stays below n, so fixed is already zero above n
  always_comb begin : extract
    int unsigned k;
    data = '0;
    k = 0;
    for (int i = 3; i < AMBA_WORD; i++) begin
      if ((i & (i - 1)) != 0) begin
        data[k] = fixed[i];
        k++;
      end
    end
  end

endmodule

// ==== hdl/ecc_core.sv ====
`timescale 1ns/10ps

module ecc_core
  import ecc_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  ecc_ctrl_if.core ctrl
);

  word_t    enc_cw;
  word_t    dec_data;
  err_cnt_t dec_err;

  logic     s1_valid;
  op_t      s1_op;
  width_t   s1_width;
  word_t    s1_word;

  // Encoder sees the live registers, they are stable while start is high
  ecc_enc u_enc (
    .width    (ctrl.width),
    .data     (ctrl.data_in),
    .codeword (enc_cw)
  );

  ecc_dec u_dec (
    .width    (s1_width),
    .codeword (s1_word),
    .data     (dec_data),
    .num_err  (dec_err)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= ctrl.start;
    end
  end

  // Stage 1 operands
  always_ff @(posedge clk) begin
    if (ctrl.start) begin
      s1_op    <= ctrl.op;
      s1_width <= ctrl.width;
      case (ctrl.op)
        OP_ENC:  s1_word <= enc_cw;
        OP_CHAN: s1_word <= enc_cw ^ ctrl.noise;  // Noise above n is dropped by the decoder
        default: s1_word <= ctrl.data_in;         // Decode takes DATA_IN as the codeword
      endcase
    end
  end

  // Stage 2 result, held until the next operation lands
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl.done     <= 1'b0;
      ctrl.data_out <= '0;
      ctrl.num_err  <= '0;
    end else begin
      ctrl.done <= s1_valid;
      if (s1_valid) begin
        if (s1_op == OP_ENC) begin
          ctrl.data_out <= s1_word;
          ctrl.num_err  <= '0;
        end else begin
          ctrl.data_out <= dec_data;
          ctrl.num_err  <= dec_err;
        end
      end
    end
  end

endmodule

// ==== hdl/ecc_top.sv ====
`timescale 1ns/10ps

module ecc_top
  import ecc_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  word_t pwdata,
  output word_t prdata
);

  ecc_ctrl_if ctrl_if ();

  // Register bank, APB side
  apb_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .ctrl    (ctrl_if.regs)
  );

  // Two-stage ECC pipeline
  ecc_core u_core (
    .clk  (clk),
    .rst  (rst),
    .ctrl (ctrl_if.core)
  );

endmodule

// ==== testbench/tb_ecc_ref.svh ====
`ifndef TB_ECC_REF_SVH
`define TB_ECC_REF_SVH

// Codeword length n for a CODEWORD_WIDTH code, code 3 acts as 32
function automatic int ref_cw_bits(width_t w);
  case (w)
    2'd0:    return 8;
    2'd1:    return 16;
    default: return 32;
  endcase
endfunction

function automatic int ref_data_bits(width_t w);
  case (w)
    2'd0:    return 4;
    2'd1:    return 11;
    default: return 26;
  endcase
endfunction

function automatic word_t ref_mask(int bits);
  if (bits >= 32) begin
    return '1;
  end
  return (word_t'(1) << bits) - 1;
endfunction

function automatic word_t ref_encode(width_t w, word_t data);
  int    n;
  int    k;
  word_t cw;
  n  = ref_cw_bits(w);
  cw = '0;
  k  = 0;
  for (int i = 1; i < n; i++) begin
    if ((i & (i - 1)) != 0) begin  // Not a power of two
      cw[i] = data[k];
      k++;
    end
  end
  for (int p = 1; p < n; p = p * 2) begin
    for (int i = 1; i < n; i++) begin
      if (i != p && (i & p) != 0) begin
        cw[p] = cw[p] ^ cw[i];
      end
    end
  end
  for (int i = 1; i < n; i++) begin
    cw[0] = cw[0] ^ cw[i];  // Even parity over the rest
  end
  return cw;
endfunction

function automatic void ref_decode(width_t w, word_t cw, output word_t data,
                                   output word_t nerr);
  int    n;
  int    k;
  int    syn;
  bit    par;
  word_t c;
  n   = ref_cw_bits(w);
  c   = cw & ref_mask(n);
  syn = 0;
  par = 1'b0;
  for (int i = 0; i < n; i++) begin
    if (c[i]) begin
      par = ~par;
      syn = syn ^ i;
    end
  end
  if (par) begin
    c[syn] = ~c[syn];
    nerr   = 1;
  end else if (syn != 0) begin
    nerr = 2;  // Left uncorrected
  end else begin
    nerr = 0;
  end
  data = '0;
  k    = 0;
  for (int i = 1; i < n; i++) begin
    if ((i & (i - 1)) != 0) begin
      data[k] = c[i];
      k++;
    end
  end
endfunction

function automatic void ref_channel(width_t w, word_t data, word_t noise,
                                    output word_t data_out, output word_t nerr);
  ref_decode(w, ref_encode(w, data) ^ noise, data_out, nerr);
endfunction

`endif

// ==== testbench/tb_ecc_top.sv ====
`timescale 1ns/10ps

module tb_ecc_top
  import ecc_pkg::*;
();

  logic  clk;
  logic  rst;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  word_t prdata;

  string name_q[$];
  word_t exp_q[$];
  word_t act_q[$];
  int    pushed = 0;
  int    checked = 0;
  int    cycles = 0;

  `include "tb_ecc_ref.svh"

  ecc_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Roughly twice what the full sequence takes
  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= 20000) begin
      $display("Test failures found");
      $fatal(1, "simulation timed out after %0d cycles", cycles);
    end
  end

  task automatic check_equal(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("Test failures found");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic push_check(string name, word_t expected, word_t actual);
    name_q.push_back(name);
    exp_q.push_back(expected);
    act_q.push_back(actual);
    pushed++;
  endtask

  task automatic apb_write(addr_t addr, word_t data);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(posedge clk);  // Write lands on this edge
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(addr_t addr, output word_t data);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #1;
    data = prdata;  // Mid access cycle
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_expect(addr_t addr, string name, word_t expected);
    word_t v;
    apb_read(addr, v);
    push_check(name, expected, v);
  endtask

  // Pipeline latency is two cycles after the CTRL write
  task automatic start_op(op_t op, width_t w, word_t data, word_t noise);
    apb_write(REG_NOISE, noise);
    apb_write(REG_DATA_IN, data);
    apb_write(REG_CODEWORD_WIDTH, word_t'(w));
    apb_write(REG_CTRL, word_t'(op));
    repeat (2) @(posedge clk);
  endtask

  task automatic result_expect(word_t exp_data, word_t exp_err);
    read_expect(REG_DATA_OUT, "DATA_OUT", exp_data);
    read_expect(REG_NUM_OF_ERRORS, "NUM_OF_ERRORS", exp_err);
  endtask

  initial begin : compare
    string name;
    word_t exp_v;
    word_t act_v;
    forever begin
      @(negedge clk);
      while (exp_q.size() > 0) begin
        name  = name_q.pop_front();
        exp_v = exp_q.pop_front();
        act_v = act_q.pop_front();
        check_equal(name, exp_v, act_v);
        checked++;
      end
    end
  end

  initial begin : stimulus
    word_t  data;
    word_t  noise;
    word_t  cw;
    word_t  wval;
    word_t  exp_data;
    word_t  exp_err;
    width_t w;
    int     n;
    int     p0;
    int     p1;
    void'($urandom(32'h14730dd5));
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Register access
    read_expect(REG_CTRL, "CTRL", '0);
    read_expect(REG_DATA_IN, "DATA_IN", '0);
    read_expect(REG_CODEWORD_WIDTH, "CODEWORD_WIDTH", '0);
    read_expect(REG_NOISE, "NOISE", '0);
    result_expect('0, '0);
    data  = $urandom;
    noise = $urandom;
    wval  = $urandom;
    apb_write(REG_DATA_IN, data);
    apb_write(REG_NOISE, noise);
    apb_write(REG_CODEWORD_WIDTH, wval);
    apb_write(REG_CTRL, 32'hFFFF_FFFF);  // Op 3, nothing starts
    apb_write(20'h18, $urandom);
    apb_write(REG_DATA_OUT, $urandom);
    read_expect(20'h18, "UNUSED_0x18", '0);
    read_expect(REG_CTRL, "CTRL", 32'd3);
    read_expect(REG_DATA_IN, "DATA_IN", data);
    read_expect(REG_CODEWORD_WIDTH, "CODEWORD_WIDTH", wval & 32'd3);
    read_expect(REG_NOISE, "NOISE", noise);
    result_expect('0, '0);

    // Each encode follows a double-error decode so a stale error count would show
    for (int wi = 0; wi < 3; wi++) begin
      for (int it = 0; it < 32; it++) begin
        w    = width_t'(wi);
        data = $urandom;
        // Bits 0 and 1 flipped give even parity with syndrome 1
        start_op(OP_DEC, w, ref_encode(w, data) ^ 32'h3, '0);
        result_expect(data & ref_mask(ref_data_bits(w)), 32'd2);
        start_op(OP_ENC, w, data, $urandom);
        result_expect(ref_encode(w, data), '0);
      end
    end

    // Channel, no noise or one flipped bit
    for (int wi = 0; wi < 3; wi++) begin
      for (int it = 0; it < 32; it++) begin
        w     = width_t'(wi);
        n     = ref_cw_bits(w);
        data  = $urandom;
        noise = (it % 4 == 0) ? '0 : (word_t'(1) << ($urandom % n));
        start_op(OP_CHAN, w, data, noise);
        result_expect(data & ref_mask(ref_data_bits(w)), word_t'($countones(noise)));
      end
    end

    // Channel, two flipped bits
    for (int wi = 0; wi < 3; wi++) begin
      for (int it = 0; it < 32; it++) begin
        w     = width_t'(wi);
        n     = ref_cw_bits(w);
        data  = $urandom;
        p0    = $urandom % n;
        p1    = (p0 + 1 + $urandom % (n - 1)) % n;  // Always differs from p0
        noise = (word_t'(1) << p0) | (word_t'(1) << p1);
        ref_channel(w, data, noise, exp_data, exp_err);
        start_op(OP_CHAN, w, data, noise);
        result_expect(exp_data, 32'd2);
      end
    end

    // Reserved op keeps the last result
    apb_write(REG_CTRL, 32'd3);
    repeat (2) @(posedge clk);
    read_expect(REG_CTRL, "CTRL", 32'd3);
    result_expect(exp_data, 32'd2);

    // Noise only above n
    for (int wi = 0; wi < 2; wi++) begin
      for (int it = 0; it < 8; it++) begin
        w     = width_t'(wi);
        data  = $urandom;
        noise = $urandom & ~ref_mask(ref_cw_bits(w));
        start_op(OP_CHAN, w, data, noise);
        result_expect(data & ref_mask(ref_data_bits(w)), '0);
      end
    end

    // Decode, half clean codewords with a random flip, half pure noise
    for (int it = 0; it < 96; it++) begin
      w = width_t'($urandom % 4);
      if (it % 2 == 1) begin
        cw = ref_encode(w, $urandom) ^ (word_t'(1) << ($urandom % 32));
      end else begin
        cw = $urandom;
      end
      ref_decode(w, cw, exp_data, exp_err);
      start_op(OP_DEC, w, cw, $urandom);
      result_expect(exp_data, exp_err);
    end

    while (checked < pushed) begin
      @(posedge clk);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== ecc_apb.f ====
+incdir+testbench
hdl/ecc_pkg.sv
hdl/ecc_ctrl_if.sv
hdl/apb_regs.sv
hdl/ecc_enc.sv
hdl/ecc_dec.sv
hdl/ecc_core.sv
hdl/ecc_top.sv
testbench/tb_ecc_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ecc_apb testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_ecc_apb

verilator --binary --timing -Wno-fatal \
  --top-module tb_ecc_top \
  -f ecc_apb.f \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
